// ==== core.f ====
isa_pkg.sv
cpu_pkg.sv
fetch_unit.sv
regfile.sv
decode_unit.sv
id_ex.sv
execute_unit.sv
pipeline_ctrl.sv
core_top.sv
core_checker.sv
tb_core.sv

// ==== core_checker.sv ====
`default_nettype none

module core_checker
    import cpu_pkg::*, isa_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  wb_req_t wb_req,
    input  logic    wb_we,
    input  logic    wb_ack,
    input  retire_t retire,
    output logic    done,
    output int      error_count,
    output int      check_count
);

    typedef struct packed {
        logic        known;    // Opcode is in the subset.
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } expect_t;

    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic        seen_ack;
    logic        open_req;     // Request left without ack last cycle.
    logic [31:0] open_adr;
    int          loop_hits;
    expect_t     want;
    int          errors = 0;
    int          checks = 0;
    logic        finished = 1'b0;

    assign done        = finished;
    assign error_count = errors;
    assign check_count = checks;

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction on the model register file.
    function automatic expect_t predict(input logic [31:0] pc, input logic [31:0] inst);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        a         = model_regs[inst[19:15]];
        b         = model_regs[inst[24:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_u     = {inst[31:12], 12'd0};
        imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e.known   = 1'b1;
        e.pc      = pc;
        e.next_pc = pc + 32'd4;
        e.rd      = inst[11:7];
        e.data    = 32'd0;
        case (inst[6:0])
            op_reg:   e.data = alu_ref(inst[14:12], inst[30], a, b);
            op_imm:   e.data = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
            op_lui:   e.data = imm_u;
            op_auipc: e.data = pc + imm_u;
            op_jal: begin
                e.data    = pc + 32'd4; // Link.
                e.next_pc = pc + imm_j;
            end
            default:  e.known = 1'b0;
        endcase
        return e;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            if (retire.valid || wb_req.cyc) begin
                errors++;
                $display("ERROR @%0t: retire.valid or cyc high during reset", $time);
            end
            for (int r = 0; r < 32; r++) begin
                model_regs[r[4:0]] = 32'd0;
            end
            model_pc  = reset_pc;
            seen_ack  = 1'b0;
            open_req  = 1'b0;
            loop_hits = 0;
        end else begin
            if (wb_we) begin
                errors++;
                $display("ERROR @%0t: write enable set on the fetch bus", $time);
            end
            if (open_req && (!wb_req.cyc || !wb_req.stb || wb_req.adr != open_adr)) begin
                errors++;
                $display("ERROR @%0t: Wishbone request changed before ack", $time);
            end
            if (retire.valid) begin
                if (!seen_ack) begin
                    errors++;
                    $display("ERROR @%0t: retire before the first fetch", $time);
                end
                want = predict(model_pc, tb_core.imem[model_pc[9:2]]);
                checks++;
                if (!want.known) begin
                    errors++;
                    $display("ERROR @%0t: model reached unsupported word at pc %h",
                             $time, model_pc);
                end else if (retire.pc !== want.pc || retire.rd !== want.rd
                             || retire.wreg !== 1'b1 || retire.data !== want.data) begin
                    errors++;
                    $display("ERROR @%0t: retired pc %h rd x%0d data %h wreg %b", $time,
                             retire.pc, retire.rd, retire.data, retire.wreg);
                    $display("ERROR @%0t: expected pc %h rd x%0d data %h wreg 1", $time,
                             want.pc, want.rd, want.data);
                end
                if (want.rd != nop_reg_addr) begin
                    model_regs[want.rd] = want.data;
                end
                if (want.next_pc == want.pc) begin
                    loop_hits++;            // Final jump to itself.
                    finished = (loop_hits >= 3);
                end
                model_pc = want.next_pc;
            end
            open_req = wb_req.cyc && wb_req.stb && !wb_ack;
            open_adr = wb_req.adr;
            seen_ack = seen_ack || (wb_req.cyc && wb_ack);
        end
    end

endmodule

`default_nettype wire

// ==== core_top.sv ====
`default_nettype none

module core_top
    import cpu_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    output wb_req_t                  wb_req,
    output logic                     wb_we,
    input  logic [reg_bus_width-1:0] wb_dat_i,
    input  logic                     wb_ack,
    output retire_t                  retire
);

    fetch_t                    fetched;
    id_ex_t                    decoded;
    id_ex_t                    ex_state;
    logic [reg_addr_width-1:0] raddr1;
    logic [reg_addr_width-1:0] raddr2;
    logic [reg_bus_width-1:0]  rdata1;
    logic [reg_bus_width-1:0]  rdata2;
    logic                      uses_rs1;
    logic                      uses_rs2;
    logic [stage_num-1:0]      stall;
    logic                      flush;
    logic                      redirect_valid;
    logic [reg_bus_width-1:0]  redirect_pc;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .wb_req      (wb_req),
        .wb_we       (wb_we),
        .fetched     (fetched)
    );

    decode_unit decode_unit_i (
        .fetched  (fetched),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .decoded  (decoded)
    );

    regfile regfile_i (
        .clk    (clk),
        .rstn   (rstn),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (retire),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    id_ex id_ex_i (
        .clk    (clk),
        .rstn   (rstn),
        .stall  (stall),
        .flush  (flush),
        .id_in  (decoded),
        .ex_out (ex_state)
    );

    execute_unit execute_unit_i (
        .ex_in          (ex_state),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    pipeline_ctrl pipeline_ctrl_i (
        .decoded        (decoded),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .uses_rs1       (uses_rs1),
        .uses_rs2       (uses_rs2),
        .ex_state       (ex_state),
        .redirect_valid (redirect_valid),
        .stall          (stall),
        .flush          (flush)
    );

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;
    import isa_pkg::*;

    localparam int reg_bus_width  = 32;
    localparam int reg_addr_width = 5;
    localparam int stage_num      = 3;

    // Positions in the stall vector.
    localparam int if_stage = 0;
    localparam int id_stage = 1;
    localparam int ex_stage = 2;

    localparam logic [reg_bus_width-1:0]  reset_pc     = 32'h0000_0000;
    localparam logic [reg_addr_width-1:0] nop_reg_addr = 5'd0;

    typedef struct packed {
        logic                     valid;
        logic [reg_bus_width-1:0] pc;
        logic [reg_bus_width-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_bus_width-1:0]  pc;
        logic [2:0]                func3;
        logic [aluop_width-1:0]    aluop;
        logic                      alusrc1;
        logic                      alusrc2;
        logic [reg_bus_width-1:0]  imm;
        logic [reg_bus_width-1:0]  rs1;
        logic [reg_bus_width-1:0]  rs2;
        logic [reg_addr_width-1:0] rd;
        logic                      wreg;
        logic                      link;      // JAL.
        logic [reg_bus_width-1:0]  link_addr;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_bus_width-1:0]  pc;
        logic [reg_addr_width-1:0] rd;
        logic                      wreg;
        logic [reg_bus_width-1:0]  data;
    } retire_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic [reg_bus_width-1:0] adr;
    } wb_req_t;

    localparam wb_req_t wb_idle = '{cyc: 1'b0, stb: 1'b0, adr: reset_pc};

    localparam fetch_t fetch_bubble = '{valid: 1'b0, pc: reset_pc, inst: '0};

    localparam id_ex_t id_ex_bubble = '{
        valid:     1'b0,
        pc:        '0,
        func3:     '0,
        aluop:     {{(aluop_width - 1){1'b0}}, 1'b1} << alu_add,
        alusrc1:   src1_from_reg,
        alusrc2:   src2_from_reg,
        imm:       '0,
        rs1:       '0,
        rs2:       '0,
        rd:        nop_reg_addr,
        wreg:      1'b0,
        link:      1'b0,
        link_addr: '0
    };

endpackage

`default_nettype wire

// ==== decode_unit.sv ====
`default_nettype none

module decode_unit
    import cpu_pkg::*, isa_pkg::*;
(
    input  fetch_t                    fetched,
    input  logic [reg_bus_width-1:0]  rdata1,
    input  logic [reg_bus_width-1:0]  rdata2,
    output logic [reg_addr_width-1:0] raddr1,
    output logic [reg_addr_width-1:0] raddr2,
    output logic                      uses_rs1,
    output logic                      uses_rs2,
    output id_ex_t                    decoded
);

    inst_u                    inst;
    logic                     alt;
    logic [reg_bus_width-1:0] imm_i;
    logic [reg_bus_width-1:0] imm_u;
    logic [reg_bus_width-1:0] imm_j;

    // Shared by register and immediate forms; SUB only exists as a register op.
    function automatic logic [aluop_width-1:0] alu_onehot(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       sub_ok
    );
        logic [aluop_width-1:0] op;
        op = '0;
        case (f3)
            f3_add_sub: op[(alt_bit && sub_ok) ? alu_sub : alu_add] = 1'b1;
            f3_sll:     op[alu_sll] = 1'b1;
            f3_slt:     op[alu_slt] = 1'b1;
            f3_sltu:    op[alu_sltu] = 1'b1;
            f3_xor:     op[alu_xor] = 1'b1;
            f3_srl_sra: op[alt_bit ? alu_sra : alu_srl] = 1'b1;
            f3_or:      op[alu_or] = 1'b1;
            default:    op[alu_and] = 1'b1;
        endcase
        return op;
    endfunction

    assign inst   = fetched.inst;
    assign raddr1 = inst.r.rs1;
    assign raddr2 = inst.r.rs2;
    assign alt    = (inst.r.funct7 == funct7_alt); // Also imm[11:5] of shifts.

    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_u = {fetched.inst[31:12], 12'b0};
    assign imm_j = {{12{fetched.inst[31]}}, fetched.inst[19:12], fetched.inst[20],
                    fetched.inst[30:21], 1'b0};

    always_comb begin
        decoded  = id_ex_bubble;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        if (fetched.valid) begin
            case (inst.r.opcode)
                op_reg: begin
                    decoded.valid = 1'b1;
                    decoded.aluop = alu_onehot(inst.r.funct3, alt, 1'b1);
                    uses_rs1      = 1'b1;
                    uses_rs2      = 1'b1;
                end
                op_imm: begin
                    decoded.valid   = 1'b1;
                    decoded.aluop   = alu_onehot(inst.i.funct3, alt, 1'b0);
                    decoded.alusrc2 = src2_from_imm;
                    decoded.imm     = imm_i;
                    uses_rs1        = 1'b1;
                end
                op_lui: begin
                    decoded.valid   = 1'b1;
                    decoded.alusrc2 = src2_from_imm; // Zero plus immediate.
                    decoded.imm     = imm_u;
                end
                op_auipc: begin
                    decoded.valid   = 1'b1;
                    decoded.alusrc1 = src1_from_pc;
                    decoded.alusrc2 = src2_from_imm;
                    decoded.imm     = imm_u;
                end
                op_jal: begin
                    decoded.valid = 1'b1;
                    decoded.link  = 1'b1;
                    decoded.imm   = imm_j;
                end
                default: ;
            endcase
        end
        if (decoded.valid) begin
            decoded.pc        = fetched.pc;
            decoded.func3     = inst.i.funct3;
            decoded.rd        = inst.i.rd;
            decoded.wreg      = 1'b1;
            decoded.link_addr = fetched.pc + 32'd4;
        end
        decoded.rs1 = uses_rs1 ? rdata1 : '0;
        decoded.rs2 = uses_rs2 ? rdata2 : '0;
    end

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`default_nettype none

module execute_unit
    import cpu_pkg::*, isa_pkg::*;
(
    input  id_ex_t                   ex_in,
    output retire_t                  retire,
    output logic                     redirect_valid,
    output logic [reg_bus_width-1:0] redirect_pc
);

    logic [reg_bus_width-1:0] op1;
    logic [reg_bus_width-1:0] op2;
    logic [4:0]               shamt;
    logic [reg_bus_width-1:0] result;

    assign op1   = (ex_in.alusrc1 == src1_from_pc) ? ex_in.pc : ex_in.rs1;
    assign op2   = (ex_in.alusrc2 == src2_from_imm) ? ex_in.imm : ex_in.rs2;
    assign shamt = op2[4:0];

    always_comb begin
        case (1'b1)
            ex_in.aluop[alu_sub]:  result = op1 - op2;
            ex_in.aluop[alu_and]:  result = op1 & op2;
            ex_in.aluop[alu_or]:   result = op1 | op2;
            ex_in.aluop[alu_xor]:  result = op1 ^ op2;
            ex_in.aluop[alu_sll]:  result = op1 << shamt;
            ex_in.aluop[alu_srl]:  result = op1 >> shamt;
            ex_in.aluop[alu_sra]:  result = $unsigned($signed(op1) >>> shamt);
            ex_in.aluop[alu_slt]:  result = {31'b0, $signed(op1) < $signed(op2)};
            ex_in.aluop[alu_sltu]: result = {31'b0, op1 < op2};
            default:               result = op1 + op2; // alu_add and bubbles.
        endcase
    end

    assign retire.valid = ex_in.valid;
    assign retire.pc    = ex_in.pc;
    assign retire.rd    = ex_in.rd;
    assign retire.wreg  = ex_in.valid && ex_in.wreg;
    assign retire.data  = ex_in.link ? ex_in.link_addr : result;

    // JAL target.
    assign redirect_valid = ex_in.valid && ex_in.link;
    assign redirect_pc    = ex_in.pc + ex_in.imm;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit
    import cpu_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [stage_num-1:0]     stall,
    input  logic                     flush,
    input  logic [reg_bus_width-1:0] redirect_pc,
    input  logic [reg_bus_width-1:0] wb_dat_i,
    input  logic                     wb_ack,
    output wb_req_t                  wb_req,
    output logic                     wb_we,
    output fetch_t                   fetched
);

    logic [reg_bus_width-1:0] pc;       // Address of the next word for IF/ID.
    logic [reg_bus_width-1:0] pc_next;
    logic                     discard;  // Request in flight is stale.
    logic                     take;
    logic                     accept;

    assign wb_we = 1'b0;

    assign take = wb_req.cyc && wb_ack;

    // A word acked under an IF stall is dropped; the PC holds, so it is fetched again.
    assign accept = take && !discard && !flush && !stall[if_stage];

    always_comb begin
        pc_next = pc;
        if (flush) begin
            pc_next = redirect_pc;
        end else if (accept) begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc      <= reset_pc;
            discard <= 1'b0;
            wb_req  <= wb_idle;
        end else begin
            pc      <= pc_next;
            discard <= (discard || flush) && !take;
            // Classic cycle. Address held until ack, next request right after.
            if (!wb_req.cyc || take) begin
                wb_req.cyc <= 1'b1;
                wb_req.stb <= 1'b1;
                wb_req.adr <= pc_next;
            end
        end
    end

    // IF/ID register.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetched <= fetch_bubble;
        end else if (flush) begin
            fetched <= fetch_bubble;
        end else if (!stall[id_stage]) begin
            fetched.valid <= accept;
            fetched.pc    <= pc;
            fetched.inst  <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

// ==== id_ex.sv ====
`default_nettype none

module id_ex
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [stage_num-1:0] stall,
    input  logic                 flush,
    input  id_ex_t               id_in,
    output id_ex_t               ex_out
);

    logic insert_bubble;
    logic load;

    // ID held back while EX moves on, so EX gets a bubble.
    assign insert_bubble = flush || (stall[id_stage] && !stall[ex_stage]);
    assign load          = !stall[id_stage];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_out <= id_ex_bubble;
        end else if (insert_bubble) begin
            ex_out <= id_ex_bubble;
        end else if (load) begin
            ex_out <= id_in;
        end
    end

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Major opcodes of the supported subset.
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] funct7_alt = 7'b0100000; // SUB and SRA.

    // Bit positions in the one-hot ALU operation.
    localparam int aluop_width = 10;
    localparam int alu_add     = 0;
    localparam int alu_sub     = 1;
    localparam int alu_and     = 2;
    localparam int alu_or      = 3;
    localparam int alu_xor     = 4;
    localparam int alu_sll     = 5;
    localparam int alu_srl     = 6;
    localparam int alu_sra     = 7;
    localparam int alu_slt     = 8;
    localparam int alu_sltu    = 9;

    localparam logic src1_from_reg = 1'b0;
    localparam logic src1_from_pc  = 1'b1;
    localparam logic src2_from_reg = 1'b0;
    localparam logic src2_from_imm = 1'b1;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_u;

endpackage

`default_nettype wire

// ==== pipeline_ctrl.sv ====
`default_nettype none

module pipeline_ctrl
    import cpu_pkg::*;
(
    input  id_ex_t                    decoded,
    input  logic [reg_addr_width-1:0] raddr1,
    input  logic [reg_addr_width-1:0] raddr2,
    input  logic                      uses_rs1,
    input  logic                      uses_rs2,
    input  id_ex_t                    ex_state,
    input  logic                      redirect_valid,
    output logic [stage_num-1:0]      stall,
    output logic                      flush
);

    logic ex_writes;
    logic raw1;
    logic raw2;
    logic hazard;

    assign ex_writes = ex_state.valid && ex_state.wreg;
    assign raw1      = uses_rs1 && raddr1 != nop_reg_addr && raddr1 == ex_state.rd;
    assign raw2      = uses_rs2 && raddr2 != nop_reg_addr && raddr2 == ex_state.rd;
    assign hazard    = decoded.valid && ex_writes && (raw1 || raw2);

    assign flush = redirect_valid;

    always_comb begin
        stall = '0;
        if (hazard && !flush) begin
            stall[if_stage] = 1'b1;
            stall[id_stage] = 1'b1;
        end
        stall[ex_stage] = 1'b0; // EX always drains.
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`default_nettype none

module regfile
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [reg_addr_width-1:0] raddr1,
    input  logic [reg_addr_width-1:0] raddr2,
    input  retire_t                   wr,
    output logic [reg_bus_width-1:0]  rdata1,
    output logic [reg_bus_width-1:0]  rdata2
);

    logic [reg_bus_width-1:0] regs [1:31]; // No storage for x0.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.wreg && wr.rd != nop_reg_addr) begin
            regs[wr.rd] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == nop_reg_addr) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == nop_reg_addr) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f core.f --top-module tb_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// ==== tb_core.sv ====
`default_nettype none

module tb_core
    import cpu_pkg::*, isa_pkg::*;
();

    localparam int prog_len       = 160;
    localparam int mem_words      = 256;
    localparam int timeout_cycles = prog_len * 8 + 200;

    logic        clk = 1'b0;
    logic        rstn;
    wb_req_t     wb_req;
    logic        wb_we;
    logic [31:0] wb_dat_i = 32'd0;
    logic        wb_ack = 1'b0;
    retire_t     retire;
    logic        done;
    int          error_count;
    int          check_count;

    logic [31:0] imem [0:mem_words-1];
    int unsigned waits;
    logic        pending;
    int          slot;      // Next free word while the program is built.

    core_top core_top_i (
        .clk      (clk),
        .rstn     (rstn),
        .wb_req   (wb_req),
        .wb_we    (wb_we),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .retire   (retire)
    );

    core_checker core_checker_i (
        .clk         (clk),
        .rstn        (rstn),
        .wb_req      (wb_req),
        .wb_we       (wb_we),
        .wb_ack      (wb_ack),
        .retire      (retire),
        .done        (done),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #4 clk = ~clk;

    function automatic logic [4:0] pick_reg(input int lo, input int hi);
        int unsigned v;
        v = $urandom_range(hi, lo);
        return v[4:0];
    endfunction

    // Kinds 0..9 are ADD SUB SLL SLT SLTU XOR SRL SRA OR AND.
    function automatic logic [31:0] reg_op_word(input int kind, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = f3_add_sub;
        f7 = 7'd0;
        case (kind)
            1: f7 = funct7_alt;
            2: f3 = f3_sll;
            3: f3 = f3_slt;
            4: f3 = f3_sltu;
            5: f3 = f3_xor;
            6: f3 = f3_srl_sra;
            7: begin
                f3 = f3_srl_sra;
                f7 = funct7_alt;
            end
            8: f3 = f3_or;
            9: f3 = f3_and;
            default: ;
        endcase
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    // Kinds 0..8 are ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI.
    function automatic logic [31:0] imm_op_word(input int kind, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [31:0] rnd);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = f3_add_sub;
        imm = rnd[11:0];
        case (kind)
            1: f3 = f3_slt;
            2: f3 = f3_sltu;
            3: f3 = f3_xor;
            4: f3 = f3_or;
            5: f3 = f3_and;
            6: begin
                f3  = f3_sll;
                imm = {7'd0, rnd[4:0]};
            end
            7: begin
                f3  = f3_srl_sra;
                imm = {7'd0, rnd[4:0]};
            end
            8: begin
                f3  = f3_srl_sra;
                imm = {funct7_alt, rnd[4:0]};
            end
            default: ;
        endcase
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [19:0] imm20);
        return {imm20, rd, op};
    endfunction

    function automatic logic [31:0] jal_word(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] random_alu_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        int kind;
        kind = $urandom_range(18, 0);
        if (kind < 10) begin
            return reg_op_word(kind, rd, rs1, rs2);
        end
        return imm_op_word(kind - 10, rd, rs1, $urandom);
    endfunction

    task automatic place_word(input logic [31:0] word);
        imem[slot[7:0]] = word;
        slot++;
    endtask

    task automatic build_program();
        int          kind;
        int          skip;
        logic [4:0]  rd;
        logic [31:0] rnd;
        for (int i = 0; i < mem_words; i++) begin
            imem[i[7:0]] = {i[24:0], 7'h7f}; // Unsupported opcode.
        end
        slot = 0;
        // Start values in x1..x8, x1 negative.
        for (int r = 1; r <= 8; r++) begin
            rnd     = $urandom;
            rnd[31] = rnd[31] || (r == 1);
            place_word(upper_word(op_lui, r[4:0], rnd[31:12]));
            if (r > 1) begin
                place_word(imm_op_word(0, r[4:0], r[4:0], $urandom));
            end
        end
        for (int k = 0; k < 10; k++) begin
            place_word(reg_op_word(k, pick_reg(9, 15), 5'd1, pick_reg(2, 8)));
        end
        for (int k = 0; k < 9; k++) begin
            place_word(imm_op_word(k, pick_reg(9, 15), pick_reg(1, 8), $urandom));
        end
        while (slot < prog_len - 1) begin
            kind = $urandom_range(9, 0);
            if (kind == 9 && slot + 4 <= prog_len - 1) begin
                skip = $urandom_range(3, 1);
                place_word(jal_word((skip + 1) * 4, pick_reg(0, 31)));
                repeat (skip) begin
                    place_word(random_alu_word(pick_reg(1, 31), pick_reg(0, 31),
                                               pick_reg(0, 31)));
                end
            end else if (kind >= 7 && slot + 2 <= prog_len - 1) begin
                rd = ($urandom_range(3, 0) == 0) ? 5'd0 : pick_reg(1, 31);
                place_word(random_alu_word(rd, pick_reg(0, 31), pick_reg(0, 31)));
                if ($urandom_range(1, 0) == 1) begin
                    place_word(reg_op_word($urandom_range(9, 0), pick_reg(1, 31),
                                           pick_reg(0, 31), rd));
                end else begin
                    place_word(random_alu_word(pick_reg(1, 31), rd, pick_reg(0, 31)));
                end
            end else if (kind == 6) begin
                rnd = $urandom;
                place_word(upper_word(op_auipc, pick_reg(0, 31), rnd[19:0]));
            end else if (kind == 5) begin
                rnd = $urandom;
                place_word(upper_word(op_lui, pick_reg(0, 31), rnd[19:0]));
            end else begin
                place_word(random_alu_word(pick_reg(0, 31), pick_reg(0, 31), pick_reg(0, 31)));
            end
        end
        place_word(jal_word(0, pick_reg(0, 31))); // Jump to itself.
    endtask

    // Instruction memory with 0 to 3 wait states.
    always @(negedge clk) begin
        if (!rstn) begin
            wb_ack  <= 1'b0;
            pending = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!pending || wb_ack) begin
                waits   = $urandom_range(3, 0);
                pending = 1'b1;
            end else if (waits > 0) begin
                waits--;
            end
            wb_ack   <= (waits == 0);
            wb_dat_i <= imem[wb_req.adr[9:2]];
        end else begin
            wb_ack  <= 1'b0;
            pending = 1'b0;
        end
    end

    initial begin
        rstn = 1'b0;
        void'($urandom(32'hc001f305));
        build_program();
        repeat (5) begin
            @(negedge clk);
        end
        rstn = 1'b1;
        wait (done);
        $display("Checked %0d retired instructions, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) begin
            @(posedge clk);
        end
        $display("Timeout: the core did not reach the final loop within %0d cycles",
                 timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
